// File: source/memPwrPkg.sv
// Power-aware SRAM subsystem package
// Sizes, memory request types, bank power control and AXI4-Lite structs
package memPwrPkg;

   // Memory geometry
   localparam int unsigned NumWords      = 256;
   localparam int unsigned DataWidth     = 32;
   localparam int unsigned ByteWidth     = 8;
   localparam int unsigned BeWidth       = DataWidth / ByteWidth;
   localparam int unsigned NumPorts      = 2;
   localparam int unsigned NumBanks      = 4;
   localparam int unsigned BankWords     = NumWords / NumBanks;
   localparam int unsigned AddrWidth     = $clog2(NumWords);
   localparam int unsigned BankSelWidth  = $clog2(NumBanks);
   localparam int unsigned BankAddrWidth = AddrWidth - BankSelWidth;

   // Register map
   localparam int unsigned RegAddrWidth = 8;
   localparam logic [RegAddrWidth-1:0] RegDeepSleepOffs = 8'h0;
   localparam logic [RegAddrWidth-1:0] RegPowerGateOffs = 8'h4;

   // AXI response codes
   localparam logic [1:0] RespOkay   = 2'b00;
   localparam logic [1:0] RespSlvErr = 2'b10;

   typedef logic [AddrWidth-1:0]     addrT;
   typedef logic [BankAddrWidth-1:0] bankAddrT;
   typedef logic [BankSelWidth-1:0]  bankSelT;
   typedef logic [DataWidth-1:0]     dataT;
   typedef logic [BeWidth-1:0]       beT;

   // Request of one port, full address
   typedef struct packed {
      logic req;
      logic we;
      addrT addr;
      dataT wdata;
      beT   be;
   } memReqT;

   // Request as seen by a single bank
   typedef struct packed {
      logic     req;
      logic     we;
      bankAddrT addr;
      dataT     wdata;
      beT       be;
   } bankReqT;

   // Power state of one bank
   typedef struct packed {
      logic deepSleep;
      logic powerGate;
   } bankCtrlT;

   // Manager to subordinate
   typedef struct packed {
      logic [RegAddrWidth-1:0] awaddr;
      logic                    awvalid;
      dataT                    wdata;
      beT                      wstrb;
      logic                    wvalid;
      logic                    bready;
      logic [RegAddrWidth-1:0] araddr;
      logic                    arvalid;
      logic                    rready;
   } axiReqT;

   // Subordinate to manager
   typedef struct packed {
      logic       awready;
      logic       wready;
      logic [1:0] bresp;
      logic       bvalid;
      logic       arready;
      dataT       rdata;
      logic [1:0] rresp;
      logic       rvalid;
   } axiRspT;

endpackage

// File: source/sramBank.sv
// Behavioral SRAM bank, two ports with byte enables
// One cycle read latency; deep sleep holds data, power gating wipes it
`timescale 1ns/100ps

module sramBank (
   input  logic                                         clk_i,
   input  logic                                         rst_ni,
   input  memPwrPkg::bankReqT [memPwrPkg::NumPorts-1:0] bankReq_i,
   input  memPwrPkg::bankCtrlT                          bankCtrl_i,
   output memPwrPkg::dataT    [memPwrPkg::NumPorts-1:0] rdata_o
);

   // Storage array
   memPwrPkg::dataT memArray [memPwrPkg::BankWords];

   // Either power mode blocks access
   logic lowPower;

   assign lowPower = bankCtrl_i.deepSleep | bankCtrl_i.powerGate;

   // Array update
   // Power gating takes precedence and clears every word
   always_ff @(posedge clk_i) begin
      if (bankCtrl_i.powerGate) begin
         for (int wordIdx = 0; wordIdx < memPwrPkg::BankWords; wordIdx++) begin
            memArray[wordIdx] <= '0;
         end
      end else if (!bankCtrl_i.deepSleep) begin
         for (int portIdx = 0; portIdx < memPwrPkg::NumPorts; portIdx++) begin
            if (bankReq_i[portIdx].req && bankReq_i[portIdx].we) begin
               // Byte lane merge
               for (int byteIdx = 0; byteIdx < memPwrPkg::BeWidth; byteIdx++) begin
                  if (bankReq_i[portIdx].be[byteIdx]) begin
                     memArray[bankReq_i[portIdx].addr][byteIdx*memPwrPkg::ByteWidth +:
                        memPwrPkg::ByteWidth] <=
                        bankReq_i[portIdx].wdata[byteIdx*memPwrPkg::ByteWidth +:
                        memPwrPkg::ByteWidth];
                  end
               end
            end
         end
      end
   end

   // Read registers, one per port
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rdata_o <= '0;
      end else begin
         for (int portIdx = 0; portIdx < memPwrPkg::NumPorts; portIdx++) begin
            // Zero unless a plain read hits a powered bank
            if (bankReq_i[portIdx].req && !bankReq_i[portIdx].we && !lowPower) begin
               rdata_o[portIdx] <= memArray[bankReq_i[portIdx].addr];
            end else begin
               rdata_o[portIdx] <= '0;
            end
         end
      end
   end

endmodule

// File: source/memMultibankPwrgate.sv
// Banked memory with per-bank power control
// Upper address bits select one of the contiguous banks,
// read data is steered back with the registered bank select
`timescale 1ns/100ps

module memMultibankPwrgate (
   input  logic                                          clk_i,
   input  logic                                          rst_ni,
   input  memPwrPkg::memReqT   [memPwrPkg::NumPorts-1:0] memReq_i,
   input  memPwrPkg::bankCtrlT [memPwrPkg::NumBanks-1:0] bankCtrl_i,
   output memPwrPkg::dataT     [memPwrPkg::NumPorts-1:0] memRdata_o
);

   // Bank index per port from the address MSBs
   memPwrPkg::bankSelT [memPwrPkg::NumPorts-1:0] bankSel;

   // Requests cut per bank and read data coming back
   memPwrPkg::bankReqT [memPwrPkg::NumBanks-1:0][memPwrPkg::NumPorts-1:0] bankReq;
   memPwrPkg::dataT    [memPwrPkg::NumBanks-1:0][memPwrPkg::NumPorts-1:0] bankRdata;

   // Select and request flag delayed by the read latency
   memPwrPkg::bankSelT [memPwrPkg::NumPorts-1:0] bankSelQ;
   logic               [memPwrPkg::NumPorts-1:0] reqQ;

   always_comb begin
      for (int portIdx = 0; portIdx < memPwrPkg::NumPorts; portIdx++) begin
         bankSel[portIdx] = memReq_i[portIdx].addr[memPwrPkg::AddrWidth-1 -:
                                                   memPwrPkg::BankSelWidth];
      end
   end

   // Request demux
   // Non-selected banks see an all-zero request
   always_comb begin
      for (int bankIdx = 0; bankIdx < memPwrPkg::NumBanks; bankIdx++) begin
         for (int portIdx = 0; portIdx < memPwrPkg::NumPorts; portIdx++) begin
            bankReq[bankIdx][portIdx] = '0;
            if (memReq_i[portIdx].req &&
                bankSel[portIdx] == memPwrPkg::bankSelT'(bankIdx)) begin
               bankReq[bankIdx][portIdx].req   = 1'b1;
               bankReq[bankIdx][portIdx].we    = memReq_i[portIdx].we;
               bankReq[bankIdx][portIdx].addr  =
                  memReq_i[portIdx].addr[memPwrPkg::BankAddrWidth-1:0];
               bankReq[bankIdx][portIdx].wdata = memReq_i[portIdx].wdata;
               bankReq[bankIdx][portIdx].be    = memReq_i[portIdx].be;
            end
         end
      end
   end

   // One bank per quarter of the address space
   for (genvar bankIdx = 0; bankIdx < memPwrPkg::NumBanks; bankIdx++) begin : genBank
      sramBank bank (
         .clk_i      (clk_i),
         .rst_ni     (rst_ni),
         .bankReq_i  (bankReq[bankIdx]),
         .bankCtrl_i (bankCtrl_i[bankIdx]),
         .rdata_o    (bankRdata[bankIdx])
      );
   end

   // Remember which bank answers next cycle
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         bankSelQ <= '0;
         reqQ     <= '0;
      end else begin
         for (int portIdx = 0; portIdx < memPwrPkg::NumPorts; portIdx++) begin
            bankSelQ[portIdx] <= bankSel[portIdx];
            reqQ[portIdx]     <= memReq_i[portIdx].req;
         end
      end
   end

   // Read mux, zero after an idle cycle
   always_comb begin
      for (int portIdx = 0; portIdx < memPwrPkg::NumPorts; portIdx++) begin
         memRdata_o[portIdx] = reqQ[portIdx] ? bankRdata[bankSelQ[portIdx]][portIdx] : '0;
      end
   end

endmodule

// File: source/pwrCtrlRegs.sv
// AXI4-Lite register block for bank power control
// 0x0 deep sleep bits, 0x4 power gate bits, one bit per bank
`timescale 1ns/100ps

module pwrCtrlRegs (
   input  logic                                          clk_i,
   input  logic                                          rst_ni,
   input  memPwrPkg::axiReqT                             axiReq_i,
   output memPwrPkg::axiRspT                             axiRsp_o,
   output memPwrPkg::bankCtrlT [memPwrPkg::NumBanks-1:0] bankCtrl_o
);

   // Control registers
   logic [memPwrPkg::NumBanks-1:0] deepSleepQ;
   logic [memPwrPkg::NumBanks-1:0] powerGateQ;

   // Write channel state
   logic       wrAccept;
   logic       bvalidQ;
   logic [1:0] brespQ;

   // Read channel state
   logic            rdAccept;
   logic            rvalidQ;
   logic [1:0]      rrespQ;
   memPwrPkg::dataT rdataQ;

   // Address and data taken together, only with no response pending
   assign wrAccept = axiReq_i.awvalid & axiReq_i.wvalid & ~bvalidQ;
   assign rdAccept = axiReq_i.arvalid & ~rvalidQ;

   always_comb begin
      axiRsp_o         = '0;
      axiRsp_o.awready = wrAccept;
      axiRsp_o.wready  = wrAccept;
      axiRsp_o.bresp   = brespQ;
      axiRsp_o.bvalid  = bvalidQ;
      axiRsp_o.arready = ~rvalidQ;
      axiRsp_o.rdata   = rdataQ;
      axiRsp_o.rresp   = rrespQ;
      axiRsp_o.rvalid  = rvalidQ;
   end

   // Register update and valid flags
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         deepSleepQ <= '0;
         powerGateQ <= '0;
         bvalidQ    <= 1'b0;
         rvalidQ    <= 1'b0;
      end else begin
         if (wrAccept) begin
            bvalidQ <= 1'b1;
            // Low byte strobe gates the update
            if (axiReq_i.wstrb[0]) begin
               if (axiReq_i.awaddr == memPwrPkg::RegDeepSleepOffs) begin
                  deepSleepQ <= axiReq_i.wdata[memPwrPkg::NumBanks-1:0];
               end else if (axiReq_i.awaddr == memPwrPkg::RegPowerGateOffs) begin
                  powerGateQ <= axiReq_i.wdata[memPwrPkg::NumBanks-1:0];
               end
            end
         end else if (bvalidQ && axiReq_i.bready) begin
            bvalidQ <= 1'b0;
         end

         if (rdAccept) begin
            rvalidQ <= 1'b1;
         end else if (rvalidQ && axiReq_i.rready) begin
            rvalidQ <= 1'b0;
         end
      end
   end

   // Response payloads
   always_ff @(posedge clk_i) begin
      if (wrAccept) begin
         if (axiReq_i.awaddr == memPwrPkg::RegDeepSleepOffs ||
             axiReq_i.awaddr == memPwrPkg::RegPowerGateOffs) begin
            brespQ <= memPwrPkg::RespOkay;
         end else begin
            brespQ <= memPwrPkg::RespSlvErr;
         end
      end
      if (rdAccept) begin
         // Register in the low bits, zero above
         if (axiReq_i.araddr == memPwrPkg::RegDeepSleepOffs) begin
            rdataQ <= memPwrPkg::dataT'(deepSleepQ);
            rrespQ <= memPwrPkg::RespOkay;
         end else if (axiReq_i.araddr == memPwrPkg::RegPowerGateOffs) begin
            rdataQ <= memPwrPkg::dataT'(powerGateQ);
            rrespQ <= memPwrPkg::RespOkay;
         end else begin
            rdataQ <= '0;
            rrespQ <= memPwrPkg::RespSlvErr;
         end
      end
   end

   // Per-bank power control
   always_comb begin
      for (int bankIdx = 0; bankIdx < memPwrPkg::NumBanks; bankIdx++) begin
         bankCtrl_o[bankIdx].deepSleep = deepSleepQ[bankIdx];
         bankCtrl_o[bankIdx].powerGate = powerGateQ[bankIdx];
      end
   end

endmodule

// File: source/memPwrTop.sv
// Power-aware SRAM subsystem top
// AXI4-Lite power registers beside a four-bank, two-port memory
`timescale 1ns/100ps

module memPwrTop (
   input  logic                                        clk_i,
   input  logic                                        rst_ni,
   input  memPwrPkg::axiReqT                           axiReq_i,
   output memPwrPkg::axiRspT                           axiRsp_o,
   input  memPwrPkg::memReqT [memPwrPkg::NumPorts-1:0] memReq_i,
   output memPwrPkg::dataT   [memPwrPkg::NumPorts-1:0] memRdata_o
);

   // Power state of each bank
   memPwrPkg::bankCtrlT [memPwrPkg::NumBanks-1:0] bankCtrl;

   // Register block
   pwrCtrlRegs regs (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .axiReq_i   (axiReq_i),
      .axiRsp_o   (axiRsp_o),
      .bankCtrl_o (bankCtrl)
   );

   // Banked memory
   memMultibankPwrgate mem (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .memReq_i   (memReq_i),
      .bankCtrl_i (bankCtrl),
      .memRdata_o (memRdata_o)
   );

endmodule

// File: testbench/tbMemPwrTasks.svh
// Helpers for the power-aware SRAM testbench
// Reference model, compare tasks, AXI4-Lite and memory port drivers
`ifndef TB_MEM_PWR_TASKS_SVH
`define TB_MEM_PWR_TASKS_SVH

   // Reference read word, zero for a bank in either low-power state
   function automatic memPwrPkg::dataT expectedWord(input memPwrPkg::addrT addr);
      memPwrPkg::bankSelT bank;
      bank = memPwrPkg::bankSelT'(addr / memPwrPkg::BankWords);
      if (shadowDs[bank] || shadowPg[bank]) return '0;
      return shadowMem[addr];
   endfunction

   function automatic logic [1:0] respForOffset(input logic [7:0] addr);
      if (addr == memPwrPkg::RegDeepSleepOffs || addr == memPwrPkg::RegPowerGateOffs) begin
         return memPwrPkg::RespOkay;
      end
      return memPwrPkg::RespSlvErr;
   endfunction

   function automatic memPwrPkg::dataT regValueAt(input logic [7:0] addr);
      if (addr == memPwrPkg::RegDeepSleepOffs) return memPwrPkg::dataT'(shadowDs);
      if (addr == memPwrPkg::RegPowerGateOffs) return memPwrPkg::dataT'(shadowPg);
      return '0;
   endfunction

   task automatic verifyReadWord(input string sigName, input memPwrPkg::dataT expVal,
                                 input memPwrPkg::dataT actVal);
      if (actVal !== expVal) begin
         $display("error %s expected 0x%h actual 0x%h", sigName, expVal, actVal);
         abortRun();
      end
   endtask

   task automatic checkResp(input string sigName, input logic [1:0] expVal,
                            input logic [1:0] actVal);
      if (actVal !== expVal) begin
         $display("error %s expected 0x%h actual 0x%h", sigName, expVal, actVal);
         abortRun();
      end
   endtask

   task automatic compareRegValue(input string sigName, input memPwrPkg::dataT expVal,
                                  input memPwrPkg::dataT actVal);
      if (actVal !== expVal) begin
         $display("error %s expected 0x%h actual 0x%h", sigName, expVal, actVal);
         abortRun();
      end
   endtask

   // One falling edge per call, bounded count
   task automatic tickOrTimeout(inout int cycles, input string what);
      @(negedge clk);
      cycles++;
      if (cycles > Timeout) begin
         $display("timed out waiting for %s", what);
         abortRun();
      end
   endtask

   task automatic writeRegister(input logic [7:0] addr, input memPwrPkg::dataT data,
                                input memPwrPkg::beT strb, output logic [1:0] resp);
      int cycles;
      axiReq.awaddr  = addr;
      axiReq.awvalid = 1'b1;
      axiReq.wdata   = data;
      axiReq.wstrb   = strb;
      axiReq.wvalid  = 1'b1;
      axiReq.bready  = 1'b1;
      cycles = 0;
      @(negedge clk);
      // Address and data channels are accepted together
      while (!(axiRsp.awready && axiRsp.wready)) tickOrTimeout(cycles, "awready and wready");
      @(posedge clk);
      #DriveDelay;
      axiReq.awvalid = 1'b0;
      axiReq.wvalid  = 1'b0;
      cycles = 0;
      @(negedge clk);
      while (!axiRsp.bvalid) tickOrTimeout(cycles, "bvalid");
      resp = axiRsp.bresp;
      @(posedge clk);
      #DriveDelay;
      axiReq.bready = 1'b0;
   endtask

   task automatic readRegister(input logic [7:0] addr, output memPwrPkg::dataT data,
                               output logic [1:0] resp);
      int cycles;
      axiReq.araddr  = addr;
      axiReq.arvalid = 1'b1;
      axiReq.rready  = 1'b1;
      cycles = 0;
      @(negedge clk);
      while (!axiRsp.arready) tickOrTimeout(cycles, "arready");
      @(posedge clk);
      #DriveDelay;
      axiReq.arvalid = 1'b0;
      cycles = 0;
      @(negedge clk);
      while (!axiRsp.rvalid) tickOrTimeout(cycles, "rvalid");
      data = axiRsp.rdata;
      resp = axiRsp.rresp;
      @(posedge clk);
      #DriveDelay;
      axiReq.rready = 1'b0;
   endtask

   task automatic programRegister(input logic [7:0] addr, input memPwrPkg::dataT data,
                                  input memPwrPkg::beT strb);
      logic [1:0] resp;
      writeRegister(addr, data, strb, resp);
      checkResp("bresp", respForOffset(addr), resp);
      recordRegWrite(addr, data, strb);
   endtask

   task automatic inspectRegister(input logic [7:0] addr);
      memPwrPkg::dataT data;
      logic [1:0]      resp;
      readRegister(addr, data, resp);
      compareRegValue("rdata", regValueAt(addr), data);
      checkResp("rresp", respForOffset(addr), resp);
   endtask

   function automatic memPwrPkg::memReqT makeReq(input logic we, input memPwrPkg::addrT addr,
                                                 input memPwrPkg::dataT wdata,
                                                 input memPwrPkg::beT be);
      memPwrPkg::memReqT req;
      req.req   = 1'b1;
      req.we    = we;
      req.addr  = addr;
      req.wdata = wdata;
      req.be    = be;
      return req;
   endfunction

   function automatic memPwrPkg::memReqT readReq(input memPwrPkg::addrT addr);
      return makeReq(1'b0, addr, '0, '0);
   endfunction

   // Reads expect zero for writes and idle ports
   function automatic memPwrPkg::dataT predictPort(input memPwrPkg::memReqT req);
      return (req.req && !req.we) ? expectedWord(req.addr) : '0;
   endfunction

   // Expectations come from the shadow before this cycle's writes land
   task automatic issueMemCycle(input memPwrPkg::memReqT req0, input memPwrPkg::memReqT req1);
      memReq[0]   = req0;
      memReq[1]   = req1;
      expRdata[0] = predictPort(req0);
      expRdata[1] = predictPort(req1);
      recordMemWrite(req0);
      recordMemWrite(req1);
      @(posedge clk);
      #DriveDelay;
   endtask

   task automatic holdMemIdle();
      memReq   = '0;
      expRdata = '0;
      @(posedge clk);
      #DriveDelay;
   endtask

   // Both halves in parallel; swap puts port 1 on the lower half
   task automatic sweepAllWords(input logic swap);
      memPwrPkg::addrT lo;
      memPwrPkg::addrT hi;
      for (int w = 0; w < memPwrPkg::NumWords / 2; w++) begin
         lo = memPwrPkg::addrT'(w);
         hi = memPwrPkg::addrT'(w + memPwrPkg::NumWords / 2);
         if (swap) issueMemCycle(readReq(hi), readReq(lo));
         else issueMemCycle(readReq(lo), readReq(hi));
      end
      holdMemIdle();
   endtask

   task automatic randomReads(input int numCycles);
      memPwrPkg::memReqT req0;
      memPwrPkg::memReqT req1;
      for (int c = 0; c < numCycles; c++) begin
         req0 = '0;
         req1 = '0;
         if (randomBits(1) != 0) req0 = readReq(memPwrPkg::addrT'(randomBits(8)));
         if (randomBits(1) != 0) req1 = readReq(memPwrPkg::addrT'(randomBits(8)));
         issueMemCycle(req0, req1);
      end
      holdMemIdle();
   endtask

`endif

// File: testbench/tbMemPwr.sv
// Testbench for the power-aware SRAM subsystem
// LFSR stimulus, shadow model of array and power registers, per-cycle read check
`timescale 1ns/100ps

module tbMemPwr;

   localparam int DriveDelay = 2;
   localparam int Timeout    = 20;

   logic clk = 1'b0;
   logic rstN;
   memPwrPkg::axiReqT axiReq;
   memPwrPkg::axiRspT axiRsp;
   memPwrPkg::memReqT [memPwrPkg::NumPorts-1:0] memReq;
   memPwrPkg::dataT   [memPwrPkg::NumPorts-1:0] memRdata;

   // Shadow of all words and of both registers
   memPwrPkg::dataT shadowMem [memPwrPkg::NumWords];
   logic [memPwrPkg::NumBanks-1:0] shadowDs;
   logic [memPwrPkg::NumBanks-1:0] shadowPg;

   // Expected word for the request on the bus, then for the one just sampled
   memPwrPkg::dataT [memPwrPkg::NumPorts-1:0] expRdata;
   memPwrPkg::dataT [memPwrPkg::NumPorts-1:0] stagedExp;
   logic        checkEnable;
   logic [31:0] lfsrState;

   memPwrTop UUT (
      .clk_i      (clk),
      .rst_ni     (rstN),
      .axiReq_i   (axiReq),
      .axiRsp_o   (axiRsp),
      .memReq_i   (memReq),
      .memRdata_o (memRdata)
   );

   always #10 clk = ~clk;

   task automatic abortRun();
      $display("Simulation failed");
      $fatal(1);
   endtask

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] state);
      return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
   endfunction

   // One step per bit taken
   function automatic logic [31:0] randomBits(input int numBits);
      logic [31:0] value;
      value = '0;
      for (int bitIdx = 0; bitIdx < numBits; bitIdx++) begin
         lfsrState = lfsrNext(lfsrState);
         value     = {value[30:0], lfsrState[0]};
      end
      return value;
   endfunction

   // Accepted register write; a set gate bit wipes its bank
   task automatic recordRegWrite(input logic [7:0] addr, input memPwrPkg::dataT data,
                                 input memPwrPkg::beT strb);
      if (strb[0] && addr == memPwrPkg::RegDeepSleepOffs) begin
         shadowDs = data[memPwrPkg::NumBanks-1:0];
      end
      if (strb[0] && addr == memPwrPkg::RegPowerGateOffs) begin
         shadowPg = data[memPwrPkg::NumBanks-1:0];
      end
      for (int w = 0; w < memPwrPkg::NumWords; w++) begin
         if (shadowPg[memPwrPkg::bankSelT'(w / memPwrPkg::BankWords)]) begin
            shadowMem[memPwrPkg::addrT'(w)] = '0;
         end
      end
   endtask

   // Byte merge into the shadow, skipped for a sleeping or gated bank
   task automatic recordMemWrite(input memPwrPkg::memReqT req);
      memPwrPkg::bankSelT bank;
      memPwrPkg::dataT    mask;
      memPwrPkg::beT      beBits;
      bank   = memPwrPkg::bankSelT'(req.addr / memPwrPkg::BankWords);
      mask   = '0;
      beBits = req.be;
      for (int b = 0; b < memPwrPkg::BeWidth; b++) begin
         if (beBits[0]) mask = mask | (memPwrPkg::dataT'(8'hff) << (b * memPwrPkg::ByteWidth));
         beBits = beBits >> 1;
      end
      if (req.req && req.we && !(shadowDs[bank] || shadowPg[bank])) begin
         shadowMem[req.addr] = (shadowMem[req.addr] & ~mask) | (req.wdata & mask);
      end
   endtask

   `include "tbMemPwrTasks.svh"

   // Latch the expectation at the sampling edge
   always @(posedge clk) begin
      stagedExp = expRdata;
   end

   // Read data is stable mid-cycle
   always @(negedge clk) begin
      if (checkEnable) begin
         verifyReadWord("memRdata_o[0]", stagedExp[0], memRdata[0]);
         verifyReadWord("memRdata_o[1]", stagedExp[1], memRdata[1]);
      end
   end

   initial begin
      rstN        = 1'b0;
      axiReq      = '0;
      memReq      = '0;
      expRdata    = '0;
      checkEnable = 1'b0;
      lfsrState   = 32'h79cc;
      shadowDs    = '0;
      shadowPg    = '0;
      for (int w = 0; w < memPwrPkg::NumWords; w++) shadowMem[memPwrPkg::addrT'(w)] = '0;
      repeat (8) @(posedge clk);
      #DriveDelay;
      rstN        = 1'b1;
      checkEnable = 1'b1;

      // Reset state, then one gate pulse on all banks to zero the arrays
      inspectRegister(memPwrPkg::RegDeepSleepOffs);
      inspectRegister(memPwrPkg::RegPowerGateOffs);
      programRegister(memPwrPkg::RegPowerGateOffs, 32'hf, 4'hf);
      programRegister(memPwrPkg::RegPowerGateOffs, 32'h0, 4'hf);
      sweepAllWords(1'b0);

      // Fill both halves with random words and byte enables
      for (int w = 0; w < memPwrPkg::NumWords / 2; w++) begin
         issueMemCycle(
            makeReq(1'b1, memPwrPkg::addrT'(w), randomBits(32),
                    memPwrPkg::beT'(randomBits(4))),
            makeReq(1'b1, memPwrPkg::addrT'(w + memPwrPkg::NumWords / 2), randomBits(32),
                    memPwrPkg::beT'(randomBits(4))));
      end
      holdMemIdle();
      randomReads(200);
      // Write then read on the other port in the next cycle
      issueMemCycle(makeReq(1'b1, 8'h15, 32'hcafe0001, 4'hf), '0);
      issueMemCycle('0, readReq(8'h15));
      holdMemIdle();

      // Bank 2 asleep: writes dropped, bank 1 still written
      programRegister(memPwrPkg::RegDeepSleepOffs, 32'h4, 4'hf);
      for (int w = 0; w < 32; w++) begin
         issueMemCycle(
            makeReq(1'b1, {2'd2, memPwrPkg::bankAddrT'(randomBits(6))}, randomBits(32), 4'hf),
            makeReq(1'b1, {2'd1, memPwrPkg::bankAddrT'(w)}, randomBits(32), 4'hf));
      end
      holdMemIdle();
      randomReads(100);
      programRegister(memPwrPkg::RegDeepSleepOffs, 32'h0, 4'hf);
      sweepAllWords(1'b1);

      // Gate pulse on bank 1 only
      programRegister(memPwrPkg::RegPowerGateOffs, 32'h2, 4'hf);
      programRegister(memPwrPkg::RegPowerGateOffs, 32'h0, 4'hf);
      sweepAllWords(1'b0);

      // Register map, strobe gating and unmapped offset
      programRegister(memPwrPkg::RegDeepSleepOffs, 32'hfffffff5, 4'hf);
      inspectRegister(memPwrPkg::RegDeepSleepOffs);
      programRegister(memPwrPkg::RegDeepSleepOffs, 32'ha, 4'he);
      inspectRegister(memPwrPkg::RegDeepSleepOffs);
      programRegister(memPwrPkg::RegPowerGateOffs, 32'h9, 4'h1);
      inspectRegister(memPwrPkg::RegPowerGateOffs);
      programRegister(8'h8, 32'hf, 4'hf);
      inspectRegister(8'h8);
      inspectRegister(memPwrPkg::RegDeepSleepOffs);
      inspectRegister(memPwrPkg::RegPowerGateOffs);
      programRegister(memPwrPkg::RegDeepSleepOffs, 32'h0, 4'hf);
      programRegister(memPwrPkg::RegPowerGateOffs, 32'h0, 4'hf);
      sweepAllWords(1'b1);

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: build.f
+incdir+testbench
source/memPwrPkg.sv
source/sramBank.sv
source/memMultibankPwrgate.sv
source/pwrCtrlRegs.sv
source/memPwrTop.sv
testbench/tbMemPwr.sv

// File: run.sh
#!/bin/sh
# Compiles the subsystem and testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir &&
verilator --binary --timing --top-module tbMemPwr -f build.f -o simMemPwr ||
   { echo "BUILD FAILED"; exit 1; }
./obj_dir/simMemPwr | tee /dev/stderr | grep -q "Simulation completed successfully" &&
   echo "PASS" ||
   { echo "FAIL"; exit 1; }
